/* design/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_WIDTH     = DATA_WIDTH * WORDS_PER_LINE;
    localparam int ADDR_WIDTH     = 32;
    localparam int OFFSET_WIDTH   = 4; // byte offset within a line

    typedef enum logic [1:0] {
        lookup,
        miss,
        refill,
        refill_done
    } icache_state_e;

    typedef enum logic [1:0] {
        u_idle,
        u_load,
        u_return,
        u_done
    } uncache_state_e;

    typedef enum logic [1:0] {
        idle,
        request,
        collect
    } bridge_state_e;

endpackage

`default_nettype wire

/* design/tag_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_ram #(
    parameter int  SETS        = 256,
    localparam int INDEX_WIDTH = $clog2(SETS),
    localparam int TAG_WIDTH   = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   we,
    input  wire [INDEX_WIDTH-1:0] addr,
    input  wire [TAG_WIDTH-1:0]   tag_in,
    input  wire                   valid_in,
    output logic [TAG_WIDTH-1:0]  tag_out,
    output logic                  valid_out
);

    logic [TAG_WIDTH-1:0] tags [SETS];
    logic [SETS-1:0]      valid_bits;

    always_ff @(posedge clk) begin
        if (we) begin
            tags[addr] <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0; // cold cache
        end else if (we) begin
            valid_bits[addr] <= valid_in;
        end
    end

    // lut style read
    assign tag_out   = tags[addr];
    assign valid_out = valid_bits[addr];

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int  SETS        = 256,
    localparam int INDEX_WIDTH = $clog2(SETS)
) (
    input  wire                               clk,
    input  wire                               we,
    input  wire                               re,
    input  wire [INDEX_WIDTH-1:0]             addr,
    input  wire [icache_pkg::DATA_WIDTH-1:0]  wdata,
    output logic [icache_pkg::DATA_WIDTH-1:0] rdata
);

    logic [icache_pkg::DATA_WIDTH-1:0] mem [SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // output holds until the next enabled read
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* design/plru_array.sv */
`timescale 1ns/1ps
`default_nettype none

module plru_array #(
    parameter int  SETS        = 256,
    localparam int INDEX_WIDTH = $clog2(SETS)
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   update,
    input  wire [INDEX_WIDTH-1:0] index,
    input  wire                   hit_way,
    input  wire [INDEX_WIDTH-1:0] victim_index,
    output logic                  victim_way
);

    // one bit per set naming the lru way
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (update) begin
            lru_bits[index] <= ~hit_way; // other way becomes lru
        end
    end

    assign victim_way = lru_bits[victim_index];

endmodule

`default_nettype wire

/* design/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int  SETS        = 256,
    localparam int INDEX_WIDTH = $clog2(SETS),
    localparam int TAG_WIDTH   = icache_pkg::ADDR_WIDTH - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               inst_valid,
    input  wire [icache_pkg::ADDR_WIDTH-1:0]  inst_addr,
    input  wire                               uncached,
    input  wire                               invalidate,
    output logic                              busy,
    output logic [icache_pkg::DATA_WIDTH-1:0] inst_rdata,
    output logic                              line_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0] line_addr,
    output logic                              word_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0] word_addr,
    input  wire                               req_ready,
    input  wire                               ret_valid,
    input  wire [icache_pkg::LINE_WIDTH-1:0]  ret_line
);

    localparam int WORD_SEL_WIDTH = $clog2(icache_pkg::WORDS_PER_LINE);
    localparam int BYTE_SEL_WIDTH = icache_pkg::OFFSET_WIDTH - WORD_SEL_WIDTH;
    localparam int DW             = icache_pkg::DATA_WIDTH;

    icache_pkg::icache_state_e  state;
    icache_pkg::icache_state_e  state_next;
    icache_pkg::uncache_state_e ustate;
    icache_pkg::uncache_state_e ustate_next;

    logic                              buf_valid;
    logic                              buf_uncached;
    logic [icache_pkg::ADDR_WIDTH-1:0] buf_addr;
    logic                              acc_q;

    logic [INDEX_WIDTH-1:0]    in_index;
    logic [INDEX_WIDTH-1:0]    buf_index;
    logic [INDEX_WIDTH-1:0]    ram_index;
    logic [TAG_WIDTH-1:0]      in_tag;
    logic [TAG_WIDTH-1:0]      buf_tag;
    logic [TAG_WIDTH-1:0]      cmp_tag;
    logic                      cmp_uncached;
    logic [WORD_SEL_WIDTH-1:0] buf_word;

    logic [1:0]           hit;
    logic [1:0]           hit_q;
    logic                 hit_any_q;
    logic                 hit_load;
    logic                 icache_busy;
    logic                 uncache_busy;
    logic                 miss_detect;
    logic                 refill_write;
    logic                 victim_way;
    logic                 plru_update;
    logic                 plru_way;
    logic [1:0]           tag_we;
    logic [1:0]           data_we;
    logic [TAG_WIDTH-1:0] tag_rd [2];
    logic [1:0]           valid_rd;
    logic [DW-1:0]        word_rd [2][icache_pkg::WORDS_PER_LINE];
    logic [DW-1:0]        way_word [2];
    logic [DW-1:0]        uncache_word;

    assign in_index  = inst_addr[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
    assign in_tag    = inst_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    assign buf_index = buf_addr[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
    assign buf_tag   = buf_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    assign buf_word  = buf_addr[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];

    // incoming set on a new fetch or invalidate, buffered set otherwise
    assign ram_index    = (inst_valid || invalidate) ? in_index : buf_index;
    assign cmp_tag      = inst_valid ? in_tag : buf_tag;
    assign cmp_uncached = inst_valid ? uncached : buf_uncached;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid    <= 1'b0;
            buf_uncached <= 1'b0;
            acc_q        <= 1'b0;
        end else begin
            acc_q <= inst_valid;
            if (inst_valid) begin
                buf_valid    <= 1'b1;
                buf_uncached <= uncached;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            buf_addr <= inst_addr;
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_hit
        assign hit[w] = valid_rd[w] && (tag_rd[w] == cmp_tag) && !cmp_uncached;
    end

    assign hit_load = inst_valid || (state == icache_pkg::refill_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_q <= '0;
        end else if (hit_load) begin
            hit_q <= hit;
        end
    end

    assign hit_any_q    = |hit_q;
    assign icache_busy  = buf_valid && !buf_uncached && !hit_any_q;
    assign miss_detect  = (state == icache_pkg::lookup) && icache_busy;
    assign uncache_busy = (ustate == icache_pkg::u_load) || (ustate == icache_pkg::u_return);
    assign busy         = icache_busy || uncache_busy;

    assign inst_rdata = (ustate == icache_pkg::u_done) ? uncache_word : way_word[hit_q[1]];

    // miss raises line_req in the same cycle as busy
    assign line_req  = miss_detect || (state == icache_pkg::miss);
    assign line_addr = {buf_tag, buf_index, {icache_pkg::OFFSET_WIDTH{1'b0}}};
    assign word_req  = (ustate == icache_pkg::u_load);
    assign word_addr = {buf_addr[icache_pkg::ADDR_WIDTH-1:BYTE_SEL_WIDTH], {BYTE_SEL_WIDTH{1'b0}}};

    assign refill_write = (state == icache_pkg::refill) && ret_valid;

    always_comb begin
        tag_we = '0;
        if (refill_write) begin
            tag_we[victim_way] = 1'b1;
        end else if (invalidate) begin
            tag_we = 2'b11; // whole set
        end
    end

    assign data_we[0] = refill_write && !victim_way;
    assign data_we[1] = refill_write && victim_way;

    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_ram #(
            .SETS(SETS)
        ) u_tag (
            .clk       (clk),
            .reset     (reset),
            .we        (tag_we[w]),
            .addr      (ram_index),
            .tag_in    (buf_tag),
            .valid_in  (refill_write),
            .tag_out   (tag_rd[w]),
            .valid_out (valid_rd[w])
        );

        for (genvar b = 0; b < icache_pkg::WORDS_PER_LINE; b++) begin : g_bank
            data_ram #(
                .SETS(SETS)
            ) u_data (
                .clk   (clk),
                .we    (data_we[w]),
                .re    (hit_load),
                .addr  (ram_index),
                .wdata (ret_line[b*DW +: DW]),
                .rdata (word_rd[w][b])
            );
        end

        assign way_word[w] = word_rd[w][buf_word];
    end

    assign plru_update = (acc_q && hit_any_q) || refill_write;
    assign plru_way    = refill_write ? victim_way : hit_q[1];

    plru_array #(
        .SETS(SETS)
    ) u_plru (
        .clk          (clk),
        .reset        (reset),
        .update       (plru_update),
        .index        (buf_index),
        .hit_way      (plru_way),
        .victim_index (buf_index),
        .victim_way   (victim_way)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= icache_pkg::lookup;
            ustate <= icache_pkg::u_idle;
        end else begin
            state  <= state_next;
            ustate <= ustate_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::lookup: begin
                if (miss_detect && req_ready) begin
                    state_next = icache_pkg::refill;
                end else if (miss_detect) begin
                    state_next = icache_pkg::miss;
                end
            end
            icache_pkg::miss: begin
                if (req_ready) begin
                    state_next = icache_pkg::refill;
                end
            end
            icache_pkg::refill: begin
                if (ret_valid) begin
                    state_next = icache_pkg::refill_done;
                end
            end
            icache_pkg::refill_done: state_next = icache_pkg::lookup; // re-read the word
            default: state_next = icache_pkg::lookup;
        endcase
    end

    always_comb begin
        ustate_next = ustate;
        case (ustate)
            icache_pkg::u_idle: begin
                if (inst_valid && uncached) begin
                    ustate_next = icache_pkg::u_load;
                end
            end
            icache_pkg::u_load: begin
                if (req_ready) begin
                    ustate_next = icache_pkg::u_return;
                end
            end
            icache_pkg::u_return: begin
                if (ret_valid) begin
                    ustate_next = icache_pkg::u_done;
                end
            end
            icache_pkg::u_done: begin
                if (inst_valid && uncached) begin
                    ustate_next = icache_pkg::u_load;
                end else if (inst_valid) begin
                    ustate_next = icache_pkg::u_idle;
                end
            end
            default: ustate_next = icache_pkg::u_idle;
        endcase
    end

    // uncached word sits in slot 0
    always_ff @(posedge clk) begin
        if ((ustate == icache_pkg::u_return) && ret_valid) begin
            uncache_word <= ret_line[DW-1:0];
        end
    end

endmodule

`default_nettype wire

/* design/refill_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_bridge (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               line_req,
    input  wire [icache_pkg::ADDR_WIDTH-1:0]  line_addr,
    input  wire                               word_req,
    input  wire [icache_pkg::ADDR_WIDTH-1:0]  word_addr,
    output logic                              req_ready,
    output logic                              ret_valid,
    output logic [icache_pkg::LINE_WIDTH-1:0] ret_line,
    output logic                              mem_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  wire                               mem_gnt,
    input  wire                               mem_rvalid,
    input  wire [icache_pkg::DATA_WIDTH-1:0]  mem_rdata
);

    localparam int BEAT_WIDTH     = $clog2(icache_pkg::WORDS_PER_LINE);
    localparam int BYTES_PER_WORD = icache_pkg::DATA_WIDTH / 8;

    icache_pkg::bridge_state_e         state;
    logic                              is_line;
    logic [BEAT_WIDTH-1:0]             beat;
    logic [icache_pkg::ADDR_WIDTH-1:0] cur_addr;
    logic                              last_beat;
    logic                              beat_in;

    assign req_ready = (state == icache_pkg::idle) && (line_req || word_req);
    assign mem_req   = (state == icache_pkg::request);
    assign mem_addr  = cur_addr;
    assign beat_in   = (state == icache_pkg::collect) && mem_rvalid;
    assign last_beat = !is_line || (beat == BEAT_WIDTH'(icache_pkg::WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= icache_pkg::idle;
            ret_valid <= 1'b0;
            is_line   <= 1'b0;
            beat      <= '0;
        end else begin
            ret_valid <= 1'b0;
            case (state)
                icache_pkg::idle: begin
                    if (req_ready) begin
                        state   <= icache_pkg::request;
                        is_line <= line_req;
                        beat    <= '0;
                    end
                end
                icache_pkg::request: begin
                    if (mem_gnt) begin
                        state <= icache_pkg::collect;
                    end
                end
                icache_pkg::collect: begin
                    if (mem_rvalid) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state     <= icache_pkg::idle;
                            ret_valid <= 1'b1; // line complete
                        end else begin
                            state <= icache_pkg::request;
                        end
                    end
                end
                default: state <= icache_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready) begin
            cur_addr <= line_req ? line_addr : word_addr;
        end else if (beat_in) begin
            cur_addr <= cur_addr + icache_pkg::ADDR_WIDTH'(BYTES_PER_WORD);
        end
    end

    // word 0 at the lowest address
    always_ff @(posedge clk) begin
        if (beat_in) begin
            ret_line[beat*icache_pkg::DATA_WIDTH +: icache_pkg::DATA_WIDTH] <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* design/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int SETS = 256
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               inst_valid,
    input  wire [icache_pkg::ADDR_WIDTH-1:0]  inst_addr,
    input  wire                               uncached,
    input  wire                               invalidate,
    output logic                              busy,
    output logic [icache_pkg::DATA_WIDTH-1:0] inst_rdata,
    output logic                              mem_req,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  wire                               mem_gnt,
    input  wire                               mem_rvalid,
    input  wire [icache_pkg::DATA_WIDTH-1:0]  mem_rdata
);

    logic                              line_req;
    logic [icache_pkg::ADDR_WIDTH-1:0] line_addr;
    logic                              word_req;
    logic [icache_pkg::ADDR_WIDTH-1:0] word_addr;
    logic                              req_ready;
    logic                              ret_valid;
    logic [icache_pkg::LINE_WIDTH-1:0] ret_line;

    icache #(
        .SETS(SETS)
    ) u_icache (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_addr  (inst_addr),
        .uncached   (uncached),
        .invalidate (invalidate),
        .busy       (busy),
        .inst_rdata (inst_rdata),
        .line_req   (line_req),
        .line_addr  (line_addr),
        .word_req   (word_req),
        .word_addr  (word_addr),
        .req_ready  (req_ready),
        .ret_valid  (ret_valid),
        .ret_line   (ret_line)
    );

    // refill and uncached requests never overlap
    refill_bridge u_bridge (
        .clk        (clk),
        .reset      (reset),
        .line_req   (line_req),
        .line_addr  (line_addr),
        .word_req   (word_req),
        .word_addr  (word_addr),
        .req_ready  (req_ready),
        .ret_valid  (ret_valid),
        .ret_line   (ret_line),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

/* tests/icache_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input wire                              clk,
    input wire                              reset,
    input wire                              busy,
    input wire                              mem_req,
    input wire [icache_pkg::ADDR_WIDTH-1:0] mem_addr,
    input wire                              mem_gnt,
    input wire                              mem_rvalid
);

    int         violations = 0;
    logic [1:0] open_grants; // granted but not yet answered

    always_ff @(posedge clk) begin
        if (reset) begin
            open_grants <= '0;
        end else if (mem_req && mem_gnt && !mem_rvalid) begin
            open_grants <= open_grants + 1'b1;
        end else if (mem_rvalid && !(mem_req && mem_gnt)) begin
            open_grants <= open_grants - 1'b1;
        end
    end

    idle_after_reset: assert property (@(posedge clk) reset |=> (!busy && !mem_req))
        else begin
            violations++;
            $error("busy or mem_req high in the cycle after reset");
        end

    req_held: assert property (@(posedge clk) disable iff (reset)
        (mem_req && !mem_gnt) |=> (mem_req && $stable(mem_addr)))
        else begin
            violations++;
            $error("mem_req dropped or mem_addr changed before mem_gnt");
        end

    beat_after_grant: assert property (@(posedge clk) disable iff (reset)
        mem_rvalid |-> (open_grants != 0))
        else begin
            violations++;
            $error("mem_rvalid without an open grant");
        end

endmodule

bind icache_top icache_properties u_props (
    .clk        (clk),
    .reset      (reset),
    .busy       (busy),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_gnt    (mem_gnt),
    .mem_rvalid (mem_rvalid)
);

`default_nettype wire

/* tests/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int SETS        = 256;
    localparam int STALL_FROM  = 21; // entries from here on see memory stalls
    localparam int MISS_CYCLES = 40;

    logic                              clk;
    logic                              reset;
    logic                              inst_valid;
    logic [icache_pkg::ADDR_WIDTH-1:0] inst_addr;
    logic                              uncached;
    logic                              invalidate;
    logic                              busy;
    logic [icache_pkg::DATA_WIDTH-1:0] inst_rdata;
    logic                              mem_req;
    logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic                              mem_gnt;
    logic                              mem_rvalid;
    logic [icache_pkg::DATA_WIDTH-1:0] mem_rdata;

    logic [31:0] stim_addr[$];
    logic        stim_uncached[$];
    logic        stim_inval[$];
    int          stim_count[$];

    integer      seed = 24;
    logic        stall_en;
    logic        req_seen;
    logic        beat_pending;
    int          gnt_wait;
    int          beat_wait;
    logic [31:0] beat_addr;
    int          gnt_total = 0;
    int          gnt_start;
    int          cycle_count = 0;
    int          cycle_limit;

    icache_top #(
        .SETS(SETS)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_addr  (inst_addr),
        .uncached   (uncached),
        .invalidate (invalidate),
        .busy       (busy),
        .inst_rdata (inst_rdata),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // word address with its upper half inverted
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        logic [31:0] word_addr;
        word_addr = byte_addr >> 2;
        return word_addr ^ 32'hffff_0000;
    endfunction

    function automatic int stall_cycles();
        int r;
        r = $random(seed);
        return stall_en ? (r & 32'h7fff_ffff) % 3 : 0;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
    endtask

    task automatic add_entry(input logic [31:0] addr, input logic unc, input logic inv,
                             input int count);
        stim_addr.push_back(addr);
        stim_uncached.push_back(unc);
        stim_inval.push_back(inv);
        stim_count.push_back(count);
    endtask

    task automatic wait_for_idle();
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // address, uncached, invalidate, memory transactions
    task automatic load_table();
        add_entry(32'h0000_1000, 0, 0, 4); // cold miss in set 0
        add_entry(32'h0000_1004, 0, 0, 0);
        add_entry(32'h0000_1008, 0, 0, 0);
        add_entry(32'h0000_100c, 0, 0, 0);
        add_entry(32'h0000_2000, 0, 0, 4); // second tag in set 0
        add_entry(32'h0000_1004, 0, 0, 0);
        add_entry(32'h0000_200c, 0, 0, 0);
        add_entry(32'h0000_3000, 0, 0, 4); // evicts 0x1000
        add_entry(32'h0000_2008, 0, 0, 0);
        add_entry(32'h0000_1000, 0, 0, 4);
        add_entry(32'h0000_2008, 0, 0, 0);
        add_entry(32'h0000_5010, 1, 0, 1);
        add_entry(32'h0000_5010, 1, 0, 1); // no allocation
        add_entry(32'h0000_1004, 0, 0, 0);
        add_entry(32'h0000_5010, 0, 0, 4);
        add_entry(32'h0000_501c, 0, 0, 0);
        add_entry(32'h0000_1000, 0, 1, 0); // clear set 0
        add_entry(32'h0000_1000, 0, 0, 4);
        add_entry(32'h0000_5018, 0, 0, 0);
        add_entry(32'h0000_2004, 0, 0, 4);
        add_entry(32'h0000_100c, 0, 0, 0);
        add_entry(32'h0000_8020, 0, 0, 4); // stalled misses in set 2
        add_entry(32'h0000_8024, 0, 0, 0);
        add_entry(32'h0000_9020, 0, 0, 4);
        add_entry(32'h0000_802c, 0, 0, 0);
        add_entry(32'h0000_a020, 0, 0, 4);
        add_entry(32'h0000_8028, 0, 0, 0);
        add_entry(32'h0000_9024, 0, 0, 4);
        add_entry(32'h0000_c040, 1, 0, 1);
        add_entry(32'h0000_c040, 1, 0, 1);
        add_entry(32'h0000_8020, 0, 1, 0);
        add_entry(32'h0000_8020, 0, 0, 4);
        add_entry(32'h0000_501c, 0, 0, 0);
        add_entry(32'h0000_9028, 0, 0, 4);
    endtask

    // memory model grants after a random wait and answers each grant after a random gap
    always @(negedge clk) begin
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        if (reset !== 1'b0) begin
            req_seen     = 1'b0;
            beat_pending = 1'b0;
        end else if (beat_pending) begin
            if (beat_wait == 0) begin
                mem_rvalid   = 1'b1;
                mem_rdata    = mem_word(beat_addr);
                beat_pending = 1'b0;
            end else begin
                beat_wait--;
            end
        end else if (mem_req) begin
            if (!req_seen) begin
                req_seen = 1'b1;
                gnt_wait = stall_cycles();
            end
            if (gnt_wait == 0) begin
                mem_gnt      = 1'b1;
                req_seen     = 1'b0;
                beat_pending = 1'b1;
                beat_addr    = mem_addr;
                beat_wait    = stall_cycles();
            end else begin
                gnt_wait--;
            end
        end
    end

    always @(posedge clk) begin
        if (mem_req && mem_gnt) begin
            gnt_total <= gnt_total + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < cycle_limit)
            else stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
    end

    always @(negedge clk) begin
        assert (DUT.u_props.violations == 0)
            else stop_with_failure("a port property of the cache was violated");
    end

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst_addr  = '0;
        uncached   = 1'b0;
        invalidate = 1'b0;
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        stall_en   = 1'b0;
        load_table();
        cycle_limit = stim_addr.size() * MISS_CYCLES + 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < stim_addr.size(); i++) begin
            wait_for_idle();
            stall_en   = (i >= STALL_FROM);
            gnt_start  = gnt_total;
            inst_addr  = stim_addr[i];
            uncached   = stim_uncached[i];
            invalidate = stim_inval[i];
            inst_valid = !stim_inval[i];
            @(negedge clk);
            inst_valid = 1'b0;
            invalidate = 1'b0;
            uncached   = 1'b0;
            if (!stim_inval[i] && stim_count[i] == 0) begin
                assert (!busy) else report_mismatch("busy", busy, 0); // hit never stalls
            end
            wait_for_idle();
            assert (gnt_total - gnt_start == stim_count[i])
                else report_mismatch("mem_gnt count", gnt_total - gnt_start, stim_count[i]);
            if (!stim_inval[i]) begin
                assert (inst_rdata === mem_word(stim_addr[i]))
                    else report_mismatch("inst_rdata", inst_rdata, mem_word(stim_addr[i]));
            end
        end
        @(negedge clk);
        if (DUT.u_props.violations == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("a port property of the cache was violated");
        end
    end

endmodule

`default_nettype wire

/* icache.f */
design/icache_pkg.sv
design/tag_ram.sv
design/data_ram.sv
design/plru_array.sv
design/icache.sv
design/refill_bridge.sv
design/icache_top.sv
tests/icache_properties.sv
tests/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - design/icache_pkg.sv
      - design/tag_ram.sv
      - design/data_ram.sv
      - design/plru_array.sv
      - design/icache.sv
      - design/refill_bridge.sv
      - design/icache_top.sv
  - target: test
    files:
      - tests/icache_properties.sv
      - tests/icache_tb.sv
